// ==== list.f ====
+incdir+rtl
rtl/wb_pkg.sv
rtl/csr_file.sv
rtl/writeback.sv
rtl/int_regfile.sv
rtl/wb_top.sv
bench/wb_assert.sv
bench/wb_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module wb_tb -f list.f -Mdir obj_dir -o wb_sim
	./obj_dir/wb_sim | tee sim.log
	grep -qx "Result: PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== bench/wb_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wb_params.svh"

module wb_tb;

    typedef struct packed {
        wb_pkg::u1          valid;
        wb_pkg::u64         pc;
        wb_pkg::control_t   ctl;
        wb_pkg::u5          dst;
        wb_pkg::csr_ctype_t ctype;
        wb_pkg::csr_op_t    op;
        wb_pkg::u1          imm;
        wb_pkg::u12         csra;
        wb_pkg::u64         src;      // rs1rd, low five bits are zimm
        wb_pkg::u1          rnd_src;
        wb_pkg::u64         code;
        wb_pkg::int_type_t  irq;
        wb_pkg::u1          iv;
    } row_t;

    wb_pkg::u1               clk;
    wb_pkg::u1               reset;
    wb_pkg::memory_data_t    data_m;
    wb_pkg::u1               inter_valid;
    wb_pkg::u5               dbg_ra;
    wb_pkg::u64              dbg_rd;
    wb_pkg::writeback_data_t data_w;
    wb_pkg::u64              mepc;
    wb_pkg::u64              mtvec;
    wb_pkg::u1               is_mret;
    wb_pkg::u1               is_intexc;
    wb_pkg::csr_regs_t       regs_out;
    wb_pkg::priv_mode_t      mode_out;

    string       names[$];
    row_t        rows[$];
    wb_pkg::u64  next_pc;
    logic [15:0] lfsr;
    int          errors;
    bit          run_done;
    bit          fail_shown;

    // reference model state
    wb_pkg::mstatus_t   m_mstatus;
    wb_pkg::u64         m_mie;
    wb_pkg::u64         m_mip;
    wb_pkg::u64         m_mtvec;
    wb_pkg::u64         m_mepc;
    wb_pkg::u64         m_mcause;
    wb_pkg::priv_mode_t m_mode;
    wb_pkg::u1          m_delayed;
    logic [3:0]         m_held;
    wb_pkg::u64         m_regs [`NREGS];

    wb_top dut0 (.*);

    bind writeback wb_assert u_wb_assert (
        .clk       (clk),
        .reset     (reset),
        .data_m    (data_m),
        .data_w    (data_w),
        .is_mret   (is_mret),
        .is_intexc (is_intexc),
        .mode_out  (mode_out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // random source, x^16 + x^14 + x^13 + x^11
    //////////////////////////////////////////////////////////////////////

    function automatic wb_pkg::u1 lfsr_next_bit();
        wb_pkg::u1 b;
        b = lfsr[0];
        lfsr = {lfsr[0] ^ lfsr[2] ^ lfsr[3] ^ lfsr[5], lfsr[15:1]};
        return b;
    endfunction

    function automatic wb_pkg::u64 rand_word();
        wb_pkg::u64 v;
        v = '0;
        for (int i = 0; i < 64; i++) begin
            v = {v[62:0], lfsr_next_bit()};
        end
        return v;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // table rows
    //////////////////////////////////////////////////////////////////////

    function automatic row_t op_row(input wb_pkg::wb_sel_t sel, input wb_pkg::u5 dst);
        row_t r;
        r = '0;
        r.valid = 1'b1;
        r.ctl.wb_select = sel;
        r.ctl.reg_write = 1'b1;
        r.dst = dst;
        r.ctype = wb_pkg::NORMAL;
        r.op = wb_pkg::CSR_NONE;
        r.iv = 1'b1;
        return r;
    endfunction

    function automatic row_t csr_row(input wb_pkg::csr_op_t op, input wb_pkg::u1 imm,
                                     input wb_pkg::u64 src, input wb_pkg::u12 csra,
                                     input wb_pkg::u5 dst);
        row_t r;
        r = op_row(wb_pkg::SEL_ALU, dst);
        r.ctype = wb_pkg::CSR_INSTR;
        r.op = op;
        r.imm = imm;
        r.src = src;
        r.csra = csra;
        return r;
    endfunction

    function automatic row_t trap_row(input wb_pkg::csr_ctype_t ctype, input wb_pkg::u64 code);
        row_t r;
        r = op_row(wb_pkg::SEL_ALU, 5'd0);
        r.ctl.reg_write = 1'b0;
        r.ctype = ctype;
        r.code = code;
        r.csra = `CSR_MTVEC;
        return r;
    endfunction

    function automatic row_t irq(input row_t r, input wb_pkg::int_type_t bits, input wb_pkg::u1 iv);
        row_t q;
        q = r;
        q.irq = bits;
        q.iv = iv;
        return q;
    endfunction

    function automatic row_t rnd(input row_t r);
        row_t q;
        q = r;
        q.rnd_src = 1'b1;
        return q;
    endfunction

    task automatic add_row(input string name, input row_t r);
        row_t q;
        q = r;
        q.pc = next_pc;
        next_pc = next_pc + 64'd4;
        names.push_back(name);
        rows.push_back(q);
    endtask

    task automatic build_table();
        next_pc = 64'h1000;
        add_row("sel alu", op_row(wb_pkg::SEL_ALU, 5'd1));
        add_row("sel mem", op_row(wb_pkg::SEL_MEM, 5'd2));
        add_row("sel pc4", op_row(wb_pkg::SEL_PC4, 5'd3));
        add_row("sel imm", op_row(wb_pkg::SEL_IMM, 5'd4));
        add_row("x0 write", op_row(wb_pkg::SEL_ALU, 5'd0));
        add_row("csrrw mtvec", csr_row(wb_pkg::CSRRW, 1'b0, 64'h8000_0100, `CSR_MTVEC, 5'd5));
        add_row("csrrsi mtvec", csr_row(wb_pkg::CSRRS, 1'b1, 64'h1c, `CSR_MTVEC, 5'd6));
        add_row("csrrci mtvec", csr_row(wb_pkg::CSRRC, 1'b1, 64'h04, `CSR_MTVEC, 5'd7));
        add_row("csrrw mepc", rnd(csr_row(wb_pkg::CSRRW, 1'b0, 64'h0, `CSR_MEPC, 5'd8)));
        add_row("csrrs mepc", csr_row(wb_pkg::CSRRS, 1'b0, 64'hff00, `CSR_MEPC, 5'd9));
        add_row("csrrc mepc", csr_row(wb_pkg::CSRRC, 1'b0, 64'h0f0f, `CSR_MEPC, 5'd10));
        add_row("read mepc", csr_row(wb_pkg::CSRRS, 1'b1, 64'h0, `CSR_MEPC, 5'd11));
        add_row("exception", trap_row(wb_pkg::EXCEPTION, 64'd2));
        add_row("read mcause", csr_row(wb_pkg::CSRRS, 1'b1, 64'h0, `CSR_MCAUSE, 5'd12));
        add_row("clear mpp", csr_row(wb_pkg::CSRRC, 1'b0, 64'h1800, `CSR_MSTATUS, 5'd13));
        add_row("set mpie", csr_row(wb_pkg::CSRRS, 1'b0, 64'h80, `CSR_MSTATUS, 5'd14));
        add_row("mret", trap_row(wb_pkg::RET, 64'd0));
        add_row("user op", op_row(wb_pkg::SEL_PC4, 5'd15));
        add_row("enable mti", csr_row(wb_pkg::CSRRS, 1'b0, 64'h80, `CSR_MIE, 5'd16));
        add_row("timer irq", irq(op_row(wb_pkg::SEL_ALU, 5'd17), 3'b100, 1'b1));
        add_row("irq mcause", csr_row(wb_pkg::CSRRS, 1'b1, 64'h0, `CSR_MCAUSE, 5'd18));
        add_row("mret again", trap_row(wb_pkg::RET, 64'd0));
        add_row("held irq", irq(op_row(wb_pkg::SEL_ALU, 5'd19), 3'b100, 1'b0));
        add_row("held irq taken", op_row(wb_pkg::SEL_MEM, 5'd20));
        add_row("irq mepc", csr_row(wb_pkg::CSRRS, 1'b1, 64'h0, `CSR_MEPC, 5'd21));
    endtask

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic wb_pkg::u64 csr_value(input wb_pkg::u12 a);
        case (a)
            `CSR_MSTATUS: return m_mstatus;
            `CSR_MIE:     return m_mie;
            `CSR_MIP:     return m_mip;
            `CSR_MTVEC:   return m_mtvec;
            `CSR_MEPC:    return m_mepc;
            `CSR_MCAUSE:  return m_mcause;
            default:      return '0;
        endcase
    endfunction

    task automatic model_step(input wb_pkg::memory_data_t d, input wb_pkg::u1 iv,
                              output wb_pkg::writeback_data_t w, output wb_pkg::u1 intexc,
                              output wb_pkg::u1 mret);
        wb_pkg::int_type_t en;
        wb_pkg::u64        old;
        wb_pkg::u64        src;
        wb_pkg::u64        nv;
        wb_pkg::u1         intr;
        wb_pkg::u1         exc;
        logic [3:0]        prio;
        logic [3:0]        cause;
        old = csr_value(d.csr_ctl.csra);
        w = '0;
        w.valid = d.valid;
        w.pc = d.pc;
        w.alu_out = d.alu_out;
        w.sextimm = d.sextimm;
        w.ctl = d.ctl;
        w.wa = d.dst;
        if (d.csr_ctl.ctype == wb_pkg::CSR_INSTR || d.csr_ctl.ctype == wb_pkg::EXCEPTION) begin
            w.wd = old;
        end else begin
            case (d.ctl.wb_select)
                wb_pkg::SEL_ALU: w.wd = d.alu_out;
                wb_pkg::SEL_MEM: w.wd = d.rd;
                wb_pkg::SEL_PC4: w.wd = d.pc + 64'd4;
                default:         w.wd = d.sextimm;
            endcase
        end
        en.trint = d.int_type.trint & m_mie[7];
        en.swint = d.int_type.swint & m_mie[3];
        en.exint = d.int_type.exint & m_mie[11];
        intr = m_mstatus.mie & (|en);
        prio = en.trint ? 4'd7 : (en.swint ? 4'd3 : 4'd11);   // timer, software, external
        cause = m_delayed ? m_held : prio;
        exc = d.csr_ctl.valid && d.csr_ctl.ctype == wb_pkg::EXCEPTION;
        intexc = exc | (intr & iv) | m_delayed;
        mret = d.csr_ctl.valid && d.csr_ctl.ctype == wb_pkg::RET && !intexc;
        src = d.csr_ctl.imm ? {59'd0, d.csr_ctl.zimm} : d.csr_ctl.rs1rd;
        case (d.csr_ctl.op)
            wb_pkg::CSRRW: nv = src;
            wb_pkg::CSRRS: nv = old | src;
            wb_pkg::CSRRC: nv = old & ~src;
            default:       nv = old;
        endcase
        if (d.csr_ctl.valid) begin
            m_mip = {52'd0, d.int_type.exint, 3'd0, d.int_type.trint, 3'd0, d.int_type.swint, 3'd0};
        end
        if (intexc) begin
            m_mepc = d.pc;
            m_mcause = exc ? d.csr_ctl.code : {1'b1, 59'd0, cause};
            m_mstatus.mpie = m_mstatus.mie;
            m_mstatus.mie = 1'b0;
            m_mstatus.mpp = m_mode;
            m_mode = wb_pkg::MODE_M;
        end else if (mret) begin
            m_mode = m_mstatus.mpp;
            m_mstatus.mie = m_mstatus.mpie;
            m_mstatus.mpie = 1'b1;
        end else if (d.csr_ctl.valid && d.csr_ctl.ctype == wb_pkg::CSR_INSTR) begin
            case (d.csr_ctl.csra)
                `CSR_MSTATUS: begin
                    m_mstatus = '0;
                    m_mstatus.mie = nv[3];
                    m_mstatus.mpie = nv[7];
                    m_mstatus.mpp = wb_pkg::priv_mode_t'(nv[12:11]);
                end
                `CSR_MIE:    m_mie = nv;
                `CSR_MTVEC:  m_mtvec = nv;
                `CSR_MEPC:   m_mepc = nv;
                `CSR_MCAUSE: m_mcause = nv;
                default: begin
                end
            endcase
        end
        if (intr && !iv) begin
            m_held = prio;
        end
        m_delayed = intr & ~iv & ~m_delayed & ~exc;
        if (d.valid && d.ctl.reg_write && d.dst != 5'd0) begin
            m_regs[d.dst] = w.wd;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic abort_on_error();
        errors++;
        fail_shown = 1'b1;
        $display("Result: FAILED");
        $fatal(1, "stopping at the first mismatch");
    endtask

    task automatic check_wb(input string name, input wb_pkg::writeback_data_t exp,
                            input wb_pkg::writeback_data_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            abort_on_error();
        end
    endtask

    task automatic check_word(input string name, input wb_pkg::u64 exp, input wb_pkg::u64 act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            abort_on_error();
        end
    endtask

    task automatic check_mode(input string name, input wb_pkg::priv_mode_t exp,
                              input wb_pkg::priv_mode_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %s, actual %s", name, exp.name(), act.name());
            abort_on_error();
        end
    endtask

    task automatic check_state(input string name);
        check_word({name, " mstatus"}, m_mstatus, regs_out.mstatus);
        check_word({name, " mie"}, m_mie, regs_out.mie);
        check_word({name, " mip"}, m_mip, regs_out.mip);
        check_word({name, " mtvec"}, m_mtvec, mtvec);
        check_word({name, " mepc"}, m_mepc, mepc);
        check_word({name, " mcause"}, m_mcause, regs_out.mcause);
        check_word({name, " register"}, m_regs[dbg_ra], dbg_rd);
        check_mode({name, " mode"}, m_mode, mode_out);
    endtask

    //////////////////////////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////////////////////////

    initial begin
        wb_pkg::memory_data_t    d;
        wb_pkg::writeback_data_t exp_w;
        wb_pkg::u1               exp_intexc;
        wb_pkg::u1               exp_mret;
        wb_pkg::u5               last_dst;
        row_t                    r;
        reset = 1'b1;
        data_m = '0;
        inter_valid = 1'b0;
        dbg_ra = '0;
        lfsr = 16'd73;
        errors = 0;
        build_table();
        m_mstatus = '0;
        m_mie = '0;
        m_mip = '0;
        m_mtvec = '0;
        m_mepc = '0;
        m_mcause = '0;
        m_mode = wb_pkg::MODE_M;
        m_delayed = 1'b0;
        m_held = '0;
        for (int i = 0; i < `NREGS; i++) begin
            m_regs[i] = '0;
        end
        last_dst = '0;
        repeat (3) @(posedge clk);
        reset <= 1'b0;
        foreach (rows[i]) begin
            r = rows[i];
            d = '0;
            d.valid = r.valid;
            d.pc = r.pc;
            d.alu_out = rand_word();
            d.rd = rand_word();
            d.sextimm = rand_word();
            d.dst = r.dst;
            d.ctl = r.ctl;
            d.csr_ctl.valid = r.valid;
            d.csr_ctl.ctype = r.ctype;
            d.csr_ctl.op = r.op;
            d.csr_ctl.imm = r.imm;
            d.csr_ctl.zimm = r.src[4:0];
            d.csr_ctl.csra = r.csra;
            d.csr_ctl.rs1rd = r.rnd_src ? rand_word() : r.src;
            d.csr_ctl.code = r.code;
            d.int_type = r.irq;
            @(posedge clk);
            data_m <= d;
            inter_valid <= r.iv;
            dbg_ra <= last_dst;   // read back the previous row's destination
            @(negedge clk);
            check_state(names[i]);
            model_step(d, r.iv, exp_w, exp_intexc, exp_mret);
            check_wb(names[i], exp_w, data_w);
            check_word({names[i], " is_intexc"}, {63'd0, exp_intexc}, {63'd0, is_intexc});
            check_word({names[i], " is_mret"}, {63'd0, exp_mret}, {63'd0, is_mret});
            last_dst = r.dst;
        end
        @(posedge clk);
        data_m <= '0;
        inter_valid <= 1'b0;
        dbg_ra <= last_dst;
        @(negedge clk);
        check_state("idle");
        run_done = 1'b1;
        if (errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #1;
        repeat (rows.size() * 20 + 100) @(posedge clk);
        fail_shown = 1'b1;
        $display("watchdog: run did not finish within %0d cycles", rows.size() * 20 + 100);
        $display("Result: FAILED");
        $fatal(1, "timeout");
    end

    final begin
        if (!run_done && !fail_shown) begin
            $display("Result: FAILED");
        end
    end

endmodule

`default_nettype wire

// ==== bench/wb_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_assert (
    input wire wb_pkg::u1               clk,
    input wire wb_pkg::u1               reset,
    input wire wb_pkg::memory_data_t    data_m,
    input wire wb_pkg::writeback_data_t data_w,
    input wire wb_pkg::u1               is_mret,
    input wire wb_pkg::u1               is_intexc,
    input wire wb_pkg::priv_mode_t      mode_out
);

    // trap and return never share a cycle
    trap_ret_exclusive: assert property (@(posedge clk) disable iff (reset)
        !(is_mret && is_intexc))
        else $error("is_mret and is_intexc high in the same cycle");

    trap_enters_m: assert property (@(posedge clk) disable iff (reset)
        is_intexc |=> mode_out == wb_pkg::MODE_M)
        else $error("mode is not MODE_M one cycle after a trap");

    valid_follows: assert property (@(posedge clk) disable iff (reset)
        data_w.valid == data_m.valid)   // stage is combinational
        else $error("data_w.valid differs from data_m.valid");

endmodule

`default_nettype wire

// ==== rtl/wb_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_top (
    input  wire wb_pkg::u1            clk,
    input  wire wb_pkg::u1            reset,
    input  wire wb_pkg::memory_data_t data_m,
    input  wire wb_pkg::u1            inter_valid,
    input  wire wb_pkg::u5            dbg_ra,
    output wb_pkg::u64                dbg_rd,
    output wb_pkg::writeback_data_t   data_w,
    output wb_pkg::u64                mepc,
    output wb_pkg::u64                mtvec,
    output wb_pkg::u1                 is_mret,
    output wb_pkg::u1                 is_intexc,
    output wb_pkg::csr_regs_t         regs_out,
    output wb_pkg::priv_mode_t        mode_out
);

    //////////////////////////////////////////////////////////////////////
    // last pipeline stage and architectural registers
    //////////////////////////////////////////////////////////////////////

    writeback u_writeback (
        .clk         (clk),
        .reset       (reset),
        .data_m      (data_m),
        .inter_valid (inter_valid),
        .data_w      (data_w),
        .mepc        (mepc),
        .mtvec       (mtvec),
        .is_mret     (is_mret),
        .is_intexc   (is_intexc),
        .regs_out    (regs_out),
        .mode_out    (mode_out)
    );

    int_regfile u_int_regfile (
        .clk    (clk),
        .reset  (reset),
        .data_w (data_w),
        .dbg_ra (dbg_ra),
        .dbg_rd (dbg_rd)
    );

endmodule

`default_nettype wire

// ==== rtl/int_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wb_params.svh"

module int_regfile (
    input  wire wb_pkg::u1               clk,
    input  wire wb_pkg::u1               reset,
    input  wire wb_pkg::writeback_data_t data_w,
    input  wire wb_pkg::u5               dbg_ra,
    output wb_pkg::u64                   dbg_rd
);

    wb_pkg::u64 regs [`NREGS];
    wb_pkg::u1  we;

    // x0 is never written, so it stays at its reset value
    assign we = data_w.valid & data_w.ctl.reg_write & (data_w.wa != 5'd0);

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[data_w.wa] <= data_w.wd;
        end
    end

    assign dbg_rd = regs[dbg_ra];   // debug read, no latency

endmodule

`default_nettype wire

// ==== rtl/writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wb_params.svh"

module writeback (
    input  wire wb_pkg::u1            clk,
    input  wire wb_pkg::u1            reset,
    input  wire wb_pkg::memory_data_t data_m,
    input  wire wb_pkg::u1            inter_valid,
    output wb_pkg::writeback_data_t   data_w,
    output wb_pkg::u64                mepc,
    output wb_pkg::u64                mtvec,
    output wb_pkg::u1                 is_mret,
    output wb_pkg::u1                 is_intexc,
    output wb_pkg::csr_regs_t         regs_out,
    output wb_pkg::priv_mode_t        mode_out
);

    wb_pkg::u64         csr_rd;
    wb_pkg::u64         csr_wd;
    wb_pkg::u64         csr_src;
    wb_pkg::priv_mode_t mode_q;
    wb_pkg::priv_mode_t mode_nxt;
    wb_pkg::u1          interrupt;
    wb_pkg::u1          delayed_interrupt;
    wb_pkg::u1          exc;
    wb_pkg::u1          ret;

    assign exc = data_m.csr_ctl.valid & (data_m.csr_ctl.ctype == wb_pkg::EXCEPTION);
    assign ret = data_m.csr_ctl.valid & (data_m.csr_ctl.ctype == wb_pkg::RET);

    //////////////////////////////////////////////////////////////////////
    // register write data
    //////////////////////////////////////////////////////////////////////

    assign data_w.valid   = data_m.valid;
    assign data_w.pc      = data_m.pc;
    assign data_w.alu_out = data_m.alu_out;
    assign data_w.sextimm = data_m.sextimm;
    assign data_w.ctl     = data_m.ctl;
    assign data_w.wa      = data_m.dst;

    always_comb begin
        if (data_m.csr_ctl.ctype == wb_pkg::CSR_INSTR ||
            data_m.csr_ctl.ctype == wb_pkg::EXCEPTION) begin
            data_w.wd = csr_rd;   // old csr value
        end else begin
            unique case (data_m.ctl.wb_select)
                wb_pkg::SEL_ALU: data_w.wd = data_m.alu_out;
                wb_pkg::SEL_MEM: data_w.wd = data_m.rd;
                wb_pkg::SEL_PC4: data_w.wd = data_m.pc + 64'd4;
                default:         data_w.wd = data_m.sextimm;
            endcase
        end
    end

    // csr read-modify-write
    assign csr_src = data_m.csr_ctl.imm ? {{(`XLEN-5){1'b0}}, data_m.csr_ctl.zimm}
                                        : data_m.csr_ctl.rs1rd;

    always_comb begin
        unique case (data_m.csr_ctl.op)
            wb_pkg::CSRRW: csr_wd = csr_src;
            wb_pkg::CSRRS: csr_wd = csr_rd | csr_src;
            wb_pkg::CSRRC: csr_wd = csr_rd & ~csr_src;
            default:       csr_wd = csr_rd;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // privilege mode
    //////////////////////////////////////////////////////////////////////

    assign is_intexc = exc | (interrupt & inter_valid) | delayed_interrupt;
    assign is_mret   = ret & ~is_intexc;   // a trap wins over mret

    always_comb begin
        if (is_intexc) begin
            mode_nxt = wb_pkg::MODE_M;
        end else if (is_mret) begin
            mode_nxt = regs_out.mstatus.mpp;
        end else begin
            mode_nxt = mode_q;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            mode_q <= wb_pkg::MODE_M;
        end else begin
            mode_q <= mode_nxt;
        end
    end

    assign mode_out = mode_q;

    csr_file u_csr_file (
        .clk               (clk),
        .reset             (reset),
        .addr              (data_m.csr_ctl.csra),
        .wd                (csr_wd),
        .valid             (data_m.csr_ctl.valid),
        .ctype             (data_m.csr_ctl.ctype),
        .pc                (data_m.pc),
        .code              (data_m.csr_ctl.code),
        .mode              (mode_q),
        .int_type          (data_m.int_type),
        .inter_valid       (inter_valid),
        .rd                (csr_rd),
        .mepc              (mepc),
        .mtvec             (mtvec),
        .regs_out          (regs_out),
        .interrupt         (interrupt),
        .delayed_interrupt (delayed_interrupt)
    );

endmodule

`default_nettype wire

// ==== rtl/csr_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "wb_params.svh"

module csr_file (
    input  wire wb_pkg::u1          clk,
    input  wire wb_pkg::u1          reset,
    input  wire wb_pkg::u12         addr,
    input  wire wb_pkg::u64         wd,
    input  wire wb_pkg::u1          valid,
    input  wire wb_pkg::csr_ctype_t ctype,
    input  wire wb_pkg::u64         pc,
    input  wire wb_pkg::u64         code,
    input  wire wb_pkg::priv_mode_t mode,
    input  wire wb_pkg::int_type_t  int_type,
    input  wire wb_pkg::u1          inter_valid,
    output wb_pkg::u64              rd,
    output wb_pkg::u64              mepc,
    output wb_pkg::u64              mtvec,
    output wb_pkg::csr_regs_t       regs_out,
    output wb_pkg::u1               interrupt,
    output wb_pkg::u1               delayed_interrupt
);

    localparam int MSI_BIT = 3;
    localparam int MTI_BIT = 7;
    localparam int MEI_BIT = 11;

    wb_pkg::csr_regs_t regs;
    wb_pkg::mstatus_t  mstatus_wr;
    wb_pkg::int_type_t int_en;
    wb_pkg::u64        mip_mirror;
    wb_pkg::u64        trap_cause;
    wb_pkg::u1         exc_take;
    wb_pkg::u1         int_take;
    wb_pkg::u1         ret_take;
    wb_pkg::u1         csr_write;
    logic [3:0]        int_cause;
    logic [3:0]        held_cause;
    logic [3:0]        cause_sel;

    //////////////////////////////////////////////////////////////////////
    // interrupt recognition
    //////////////////////////////////////////////////////////////////////

    assign int_en.trint = int_type.trint & regs.mie[MTI_BIT];
    assign int_en.swint = int_type.swint & regs.mie[MSI_BIT];
    assign int_en.exint = int_type.exint & regs.mie[MEI_BIT];
    assign interrupt    = regs.mstatus.mie & (|int_en);

    always_comb begin
        if (int_en.trint) begin
            int_cause = 4'd7;   // timer first
        end else if (int_en.swint) begin
            int_cause = 4'd3;
        end else begin
            int_cause = 4'd11;
        end
    end

    // a held interrupt keeps the cause seen when it was raised
    assign cause_sel = delayed_interrupt ? held_cause : int_cause;

    assign exc_take  = valid & (ctype == wb_pkg::EXCEPTION);
    assign int_take  = (interrupt & inter_valid) | delayed_interrupt;
    assign ret_take  = valid & (ctype == wb_pkg::RET);
    assign csr_write = valid & (ctype == wb_pkg::CSR_INSTR);

    assign trap_cause = exc_take ? code : {1'b1, {(`XLEN-5){1'b0}}, cause_sel};

    always_comb begin
        mip_mirror          = '0;
        mip_mirror[MTI_BIT] = int_type.trint;
        mip_mirror[MSI_BIT] = int_type.swint;
        mip_mirror[MEI_BIT] = int_type.exint;
    end

    //////////////////////////////////////////////////////////////////////
    // read and write decode
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        unique case (addr)
            `CSR_MSTATUS: rd = regs.mstatus;
            `CSR_MIE:     rd = regs.mie;
            `CSR_MIP:     rd = regs.mip;
            `CSR_MTVEC:   rd = regs.mtvec;
            `CSR_MEPC:    rd = regs.mepc;
            `CSR_MCAUSE:  rd = regs.mcause;
            default:      rd = '0;
        endcase
    end

    always_comb begin
        mstatus_wr      = '0;   // unimplemented fields stay zero
        mstatus_wr.mie  = wd[3];
        mstatus_wr.mpie = wd[7];
        mstatus_wr.mpp  = wb_pkg::priv_mode_t'(wd[12:11]);
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            regs              <= '0;
            delayed_interrupt <= 1'b0;
        end else begin
            if (valid) begin
                regs.mip <= mip_mirror;
            end
            if (exc_take || int_take) begin
                regs.mepc         <= pc;
                regs.mcause       <= trap_cause;
                regs.mstatus.mpie <= regs.mstatus.mie;
                regs.mstatus.mie  <= 1'b0;
                regs.mstatus.mpp  <= mode;
            end else if (ret_take) begin
                regs.mstatus.mie  <= regs.mstatus.mpie;
                regs.mstatus.mpie <= 1'b1;
            end else if (csr_write) begin
                unique case (addr)
                    `CSR_MSTATUS: regs.mstatus <= mstatus_wr;
                    `CSR_MIE:     regs.mie     <= wd;
                    `CSR_MTVEC:   regs.mtvec   <= wd;
                    `CSR_MEPC:    regs.mepc    <= wd;
                    `CSR_MCAUSE:  regs.mcause  <= wd;
                    default: begin
                    end                       // mip is a mirror, not writable
                endcase
            end
            // hold for one cycle when the pipeline can't take it now
            delayed_interrupt <= interrupt & ~inter_valid & ~delayed_interrupt & ~exc_take;
        end
    end

    always_ff @(posedge clk) begin
        if (interrupt && !inter_valid) begin
            held_cause <= int_cause;
        end
    end

    assign regs_out = regs;
    assign mepc     = regs.mepc;
    assign mtvec    = regs.mtvec;

endmodule

`default_nettype wire

// ==== rtl/wb_pkg.sv ====
`default_nettype none

`include "wb_params.svh"

package wb_pkg;

    typedef logic              u1;
    typedef logic [1:0]        u2;
    typedef logic [4:0]        u5;
    typedef logic [11:0]       u12;
    typedef logic [`XLEN-1:0]  u64;

    typedef enum logic [1:0] {
        CSRRW,
        CSRRS,
        CSRRC,
        CSR_NONE
    } csr_op_t;

    typedef enum logic [1:0] {
        NORMAL,
        CSR_INSTR,
        EXCEPTION,
        RET
    } csr_ctype_t;

    typedef enum logic [1:0] {
        SEL_ALU,
        SEL_MEM,
        SEL_PC4,
        SEL_IMM
    } wb_sel_t;

    typedef enum logic [1:0] {
        MODE_U = 2'd0,
        MODE_S = 2'd1,
        MODE_M = 2'd3
    } priv_mode_t;

    // pending lines that travel with the instruction
    typedef struct packed {
        u1 trint;
        u1 swint;
        u1 exint;
    } int_type_t;

    typedef struct packed {
        u1          valid;
        csr_ctype_t ctype;
        csr_op_t    op;
        u1          imm;   // zimm form
        u5          zimm;
        u12         csra;
        u64         rs1rd;
        u64         code;  // exception cause
    } csr_control_t;

    typedef struct packed {
        wb_sel_t wb_select;
        u1       reg_write;
    } control_t;

    typedef struct packed {
        logic [50:0] pad_hi;   // 63:13
        priv_mode_t  mpp;      // 12:11
        logic [2:0]  pad_mid;  // 10:8
        u1           mpie;     // 7
        logic [2:0]  pad_lo;   // 6:4
        u1           mie;      // 3
        logic [2:0]  pad_low;  // 2:0
    } mstatus_t;

    typedef struct packed {
        mstatus_t mstatus;
        u64       mie;
        u64       mip;
        u64       mtvec;
        u64       mepc;
        u64       mcause;
    } csr_regs_t;

    typedef struct packed {
        u1            valid;
        u64           pc;
        u64           alu_out;
        u64           rd;      // load data
        u64           sextimm;
        u5            dst;
        control_t     ctl;
        csr_control_t csr_ctl;
        int_type_t    int_type;
    } memory_data_t;

    typedef struct packed {
        u1        valid;
        u64       pc;
        u64       alu_out;
        u64       sextimm;
        control_t ctl;
        u5        wa;
        u64       wd;
    } writeback_data_t;

endpackage

`default_nettype wire

// ==== rtl/wb_params.svh ====
`ifndef WB_PARAMS_SVH
`define WB_PARAMS_SVH

//////////////////////////////////////////////////////////////////////
// datapath sizes
//////////////////////////////////////////////////////////////////////

`define XLEN  64
`define NREGS 32

//////////////////////////////////////////////////////////////////////
// machine CSR addresses
//////////////////////////////////////////////////////////////////////

`define CSR_MSTATUS 12'h300
`define CSR_MIE     12'h304
`define CSR_MTVEC   12'h305
`define CSR_MEPC    12'h341
`define CSR_MCAUSE  12'h342
`define CSR_MIP     12'h344

`endif
